// File: Makefile
SIM      := verilator
TOP      := tbConvAccel
FILELIST := filelist.f
FLAGS    := --binary --timing -Wno-fatal --top-module $(TOP)
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: bankedMemory.sv
`timescale 1ns/1ps

module bankedMemory import convPkg::*; #(
    parameter int VectorSize = 4,
    parameter int MaxSize = 256
) (
    input logic clkIn,
    bankWrIf.sink wr,
    bankRdIf.sink rd,
    vectorIf.source vec
);
    localparam int RamDepth = MaxSize / VectorSize;
    localparam int LineW = $clog2(RamDepth);
    localparam int ShiftW = $clog2(VectorSize);

    // Index 0 is the data matrix, index 1 the filter
    wordByteEnT [VectorSize-1:0] wrEn [2];
    logic [VectorSize-1:0][LineW-1:0] rdAddr [2];
    logic [VectorSize-1:0] rdEn [2];
    wordT rdQ [2][VectorSize];
    logic [ShiftW-1:0] shiftQ [2];
    logic [VectorSize-1:0] validQ;
    logic lastQ;

    assign wrEn[0] = wr.dataWrEn;
    assign wrEn[1] = wr.filtWrEn;
    assign rdAddr[0] = rd.dataAddr;
    assign rdAddr[1] = rd.filtAddr;
    assign rdEn[0] = rd.dataRdEn;
    assign rdEn[1] = rd.filtRdEn;

    for (genvar m = 0; m < 2; m++) begin : gMem
        for (genvar k = 0; k < VectorSize; k++) begin : gLane
            wordT ram [RamDepth];

            always_ff @(posedge clkIn) begin
                for (int b = 0; b < WordBytes; b++) begin
                    if (wrEn[m][k][b]) begin
                        ram[wr.lineAddr][b*8 +: 8] <= wr.wrData[k][b*8 +: 8];
                    end
                end
                if (rdEn[m][k]) begin
                    rdQ[m][k] <= ram[rdAddr[m][k]];
                end
            end
        end
    end

    // Side-band follows the one-cycle read
    always_ff @(posedge clkIn) begin
        shiftQ[0] <= rd.dataShift;
        shiftQ[1] <= rd.filtShift;
        validQ <= rd.dataRdEn;
        lastQ <= rd.last;
    end

    // Reverse rotation back into window order
    always_ff @(posedge clkIn) begin
        for (int k = 0; k < VectorSize; k++) begin
            vec.dataA[k] <= rdQ[0][(k + int'(shiftQ[0])) % VectorSize];
            vec.dataB[k] <= rdQ[1][(k + int'(shiftQ[1])) % VectorSize];
            vec.laneValid[k] <= validQ[(k + int'(shiftQ[0])) % VectorSize];
        end
        vec.last <= lastQ;
    end

endmodule

// File: busWriteMapper.sv
`timescale 1ns/1ps

module busWriteMapper import convPkg::*; #(
    parameter int VectorSize = 4,
    parameter int MaxSize = 256
) (
    input logic clkIn,
    input logic rstIn,
    input busAddrT addrIn,
    input busByteEnT wrEnIn,
    input busDataT wrDataIn,
    bankWrIf.source wr
);
    localparam int LineW = $clog2(MaxSize / VectorSize);
    localparam int LineBytes = VectorSize * WordBytes;
    localparam int AddrLo = $clog2(LineBytes);
    localparam int BeatBytes = BusWords * WordBytes;
    localparam int WordW = $bits(wordT);

    logic [AddrLo-1:0] byteOff;
    logic filtSel;

    // Byte offset inside a line picks the lane pair
    assign byteOff = addrIn[AddrLo-1:0];
    // Bit above the line address picks the filter memory
    assign filtSel = addrIn[AddrLo+LineW];

    always_ff @(posedge clkIn) begin
        wr.lineAddr <= addrIn[AddrLo +: LineW];
        for (int i = 0; i < VectorSize; i++) begin
            wr.wrData[i] <= wrDataIn[(i % BusWords) * WordW +: WordW];
        end
    end

    always_ff @(posedge clkIn) begin
        wordByteEnT laneEn;
        if (rstIn) begin
            wr.dataWrEn <= '0;
            wr.filtWrEn <= '0;
        end else begin
            for (int i = 0; i < VectorSize; i++) begin
                laneEn = '0;
                if (int'(byteOff) / BeatBytes == i / BusWords) begin
                    laneEn = wrEnIn[(i % BusWords) * WordBytes +: WordBytes];
                end
                wr.dataWrEn[i] <= filtSel ? '0 : laneEn;
                wr.filtWrEn[i] <= filtSel ? laneEn : '0;
            end
        end
    end

endmodule

// File: convAccel.sv
`timescale 1ns/1ps

module convAccel import convPkg::*; #(
    parameter int VectorSize = 4,
    parameter int MaxSize = 256,
    parameter int FifoDepth = 32
) (
    input logic clkIn,
    input logic rstIn,
    input logic startIn,
    input logic [$clog2(MaxSize):0] filtRowsIn,
    input logic [$clog2(MaxSize):0] filtColsIn,
    input logic [$clog2(MaxSize):0] dataRowsIn,
    input logic [$clog2(MaxSize):0] dataColsIn,
    input busAddrT addrIn,
    input busByteEnT wrEnIn,
    input busDataT wrDataIn,
    input logic readyIn,
    output logic validOut,
    output wordT dataOut
);
    // Above the ten-stage beat pipeline
    localparam int FifoSkid = 16;

    wordT macData;
    logic macValid;
    logic wrReady;

    bankWrIf #(.VectorSize(VectorSize), .MaxSize(MaxSize)) bankWr ();
    bankRdIf #(.VectorSize(VectorSize), .MaxSize(MaxSize)) bankRd ();
    vectorIf #(.VectorSize(VectorSize)) vecBus ();

    busWriteMapper #(.VectorSize(VectorSize), .MaxSize(MaxSize)) writeMapper (
        .clkIn(clkIn),
        .rstIn(rstIn),
        .addrIn(addrIn),
        .wrEnIn(wrEnIn),
        .wrDataIn(wrDataIn),
        .wr(bankWr.source)
    );

    convAddressGen #(.VectorSize(VectorSize), .MaxSize(MaxSize)) addressGen (
        .clkIn(clkIn),
        .rstIn(rstIn),
        .startIn(startIn),
        .filtRowsIn(filtRowsIn),
        .filtColsIn(filtColsIn),
        .dataRowsIn(dataRowsIn),
        .dataColsIn(dataColsIn),
        .wrReady(wrReady),
        .rd(bankRd.source)
    );

    bankedMemory #(.VectorSize(VectorSize), .MaxSize(MaxSize)) memory (
        .clkIn(clkIn),
        .wr(bankWr.sink),
        .rd(bankRd.sink),
        .vec(vecBus.source)
    );

    vectorMac #(.VectorSize(VectorSize)) mac (
        .clkIn(clkIn),
        .rstIn(rstIn),
        .vec(vecBus.sink),
        .macData(macData),
        .macValid(macValid)
    );

    resultFifo #(.FifoDepth(FifoDepth), .FifoSkid(FifoSkid)) fifo (
        .clkIn(clkIn),
        .rstIn(rstIn),
        .wrData(macData),
        .wrValid(macValid),
        .wrReady(wrReady),
        .dataOut(dataOut),
        .validOut(validOut),
        .readyIn(readyIn)
    );

endmodule

// File: convAddressGen.sv
`timescale 1ns/1ps

module convAddressGen import convPkg::*; #(
    parameter int VectorSize = 4,
    parameter int MaxSize = 256
) (
    input logic clkIn,
    input logic rstIn,
    input logic startIn,
    input logic [$clog2(MaxSize):0] filtRowsIn,
    input logic [$clog2(MaxSize):0] filtColsIn,
    input logic [$clog2(MaxSize):0] dataRowsIn,
    input logic [$clog2(MaxSize):0] dataColsIn,
    input logic wrReady,
    bankRdIf.source rd
);
    localparam int CntW = $clog2(MaxSize);
    localparam int ShiftW = $clog2(VectorSize);
    localparam int GrpW = CntW - ShiftW;
    localparam int LineW = $clog2(MaxSize / VectorSize);

    convStateT state;

    // End values captured on start
    logic [GrpW-1:0] maxGrp;
    logic [ShiftW-1:0] lastLane;
    logic [CntW-1:0] maxFiltRow;
    logic [CntW-1:0] maxDataRow;
    logic [CntW-1:0] maxDataCol;
    logic [CntW:0] filtCols;
    logic [CntW:0] dataCols;
    logic [CntW:0] filtColsM1;

    // Window counters, fastest first
    logic [GrpW-1:0] grpCnt;
    logic [CntW-1:0] filtRowCnt;
    logic [CntW-1:0] dataColCnt;
    logic [CntW-1:0] dataRowCnt;
    logic [CntW-1:0] grpBase;
    logic grpEnd, filtRowEnd, dataColEnd, dataRowEnd, windowEnd, issue;

    // Address pipeline
    logic [CntW-1:0] dataRow2, dataCol2, filtRowAddr2, filtCol2;
    logic [CntW-1:0] dataRowAddr3, dataCol3, filtAddr3;
    logic [CntW-1:0] dataAddr4, filtAddr4;
    logic [ShiftW-1:0] dataShift5, filtShift5;
    logic [VectorSize-1:0][LineW-1:0] dataLine5, filtLine5;
    logic [VectorSize-1:0] rdEn2, rdEn3, rdEn4, rdEn5;
    logic last2, last3, last4, last5;

    assign filtColsM1 = filtColsIn - 1'b1;
    assign grpBase = {grpCnt, {ShiftW{1'b0}}};
    assign grpEnd = grpCnt == maxGrp;
    assign filtRowEnd = filtRowCnt == maxFiltRow;
    assign dataColEnd = dataColCnt == maxDataCol;
    assign dataRowEnd = dataRowCnt == maxDataRow;
    assign windowEnd = grpEnd && filtRowEnd;
    // Full stall while the FIFO is above its almost-full level
    assign issue = (state == stateCalc) && wrReady;

    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            state <= stateIdle;
            grpCnt <= '0;
            filtRowCnt <= '0;
            dataColCnt <= '0;
            dataRowCnt <= '0;
        end else if (state == stateIdle) begin
            if (startIn) begin
                state <= stateCalc;
            end
        end else if (issue) begin
            grpCnt <= grpEnd ? '0 : grpCnt + 1'b1;
            if (grpEnd) begin
                filtRowCnt <= filtRowEnd ? '0 : filtRowCnt + 1'b1;
            end
            if (windowEnd) begin
                dataColCnt <= dataColEnd ? '0 : dataColCnt + 1'b1;
            end
            if (windowEnd && dataColEnd) begin
                dataRowCnt <= dataRowEnd ? '0 : dataRowCnt + 1'b1;
                if (dataRowEnd) begin
                    state <= stateIdle;
                end
            end
        end
    end

    always_ff @(posedge clkIn) begin
        if (state == stateIdle && startIn) begin
            maxGrp <= filtColsM1[CntW-1:ShiftW];
            lastLane <= filtColsM1[ShiftW-1:0];
            maxFiltRow <= CntW'(filtRowsIn - 1'b1);
            maxDataRow <= CntW'(dataRowsIn - filtRowsIn);
            maxDataCol <= CntW'(dataColsIn - filtColsIn);
            filtCols <= filtColsIn;
            dataCols <= dataColsIn;
        end
    end

    always_ff @(posedge clkIn) begin
        dataRow2 <= dataRowCnt + filtRowCnt;
        dataCol2 <= dataColCnt + grpBase;
        filtRowAddr2 <= CntW'(filtRowCnt * filtCols);
        filtCol2 <= grpBase;

        dataRowAddr3 <= CntW'(dataRow2 * dataCols);
        dataCol3 <= dataCol2;
        filtAddr3 <= filtRowAddr2 + filtCol2;

        dataAddr4 <= dataRowAddr3 + dataCol3;
        filtAddr4 <= filtAddr3;

        // Low bits give the bank of window word 0
        dataShift5 <= dataAddr4[ShiftW-1:0];
        filtShift5 <= filtAddr4[ShiftW-1:0];
        for (int j = 0; j < VectorSize; j++) begin
            dataLine5[j] <= LineW'((dataAddr4 + CntW'(j)) >> ShiftW);
            filtLine5[j] <= LineW'((filtAddr4 + CntW'(j)) >> ShiftW);
        end

        // Rotate word j onto bank (j + shift) mod VectorSize
        rd.dataShift <= dataShift5;
        rd.filtShift <= filtShift5;
        for (int k = 0; k < VectorSize; k++) begin
            rd.dataAddr[k] <= dataLine5[(k + VectorSize - int'(dataShift5)) % VectorSize];
            rd.filtAddr[k] <= filtLine5[(k + VectorSize - int'(filtShift5)) % VectorSize];
        end
    end

    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            rdEn2 <= '0;
            rdEn3 <= '0;
            rdEn4 <= '0;
            rdEn5 <= '0;
            last2 <= 1'b0;
            last3 <= 1'b0;
            last4 <= 1'b0;
            last5 <= 1'b0;
            rd.dataRdEn <= '0;
            rd.filtRdEn <= '0;
            rd.last <= 1'b0;
        end else begin
            // Final column group only reads its remaining lanes
            for (int j = 0; j < VectorSize; j++) begin
                rdEn2[j] <= issue && (!grpEnd || j <= int'(lastLane));
            end
            last2 <= issue && windowEnd;
            rdEn3 <= rdEn2;
            rdEn4 <= rdEn3;
            rdEn5 <= rdEn4;
            last3 <= last2;
            last4 <= last3;
            last5 <= last4;
            for (int k = 0; k < VectorSize; k++) begin
                rd.dataRdEn[k] <= rdEn5[(k + VectorSize - int'(dataShift5)) % VectorSize];
                rd.filtRdEn[k] <= rdEn5[(k + VectorSize - int'(filtShift5)) % VectorSize];
            end
            rd.last <= last5;
        end
    end

endmodule

// File: convIfs.sv
`timescale 1ns/1ps

// Registered bus writes fanned out to the bank lanes
interface bankWrIf import convPkg::*; #(
    parameter int VectorSize = 4,
    parameter int MaxSize = 256
) ();
    localparam int LineW = $clog2(MaxSize / VectorSize);

    logic [LineW-1:0] lineAddr;
    wordT [VectorSize-1:0] wrData;
    wordByteEnT [VectorSize-1:0] dataWrEn;
    wordByteEnT [VectorSize-1:0] filtWrEn;

    modport source (output lineAddr, wrData, dataWrEn, filtWrEn);
    modport sink (input lineAddr, wrData, dataWrEn, filtWrEn);
endinterface

// One read beat per cycle, addresses already in bank order
interface bankRdIf #(
    parameter int VectorSize = 4,
    parameter int MaxSize = 256
) ();
    localparam int LineW = $clog2(MaxSize / VectorSize);
    localparam int ShiftW = $clog2(VectorSize);

    logic [VectorSize-1:0][LineW-1:0] dataAddr;
    logic [VectorSize-1:0][LineW-1:0] filtAddr;
    logic [VectorSize-1:0] dataRdEn;
    logic [VectorSize-1:0] filtRdEn;
    logic [ShiftW-1:0] dataShift;
    logic [ShiftW-1:0] filtShift;
    logic last;

    modport source (output dataAddr, filtAddr, dataRdEn, filtRdEn, dataShift, filtShift, last);
    modport sink (input dataAddr, filtAddr, dataRdEn, filtRdEn, dataShift, filtShift, last);
endinterface

// Realigned operand vectors, lane k is window word k
interface vectorIf import convPkg::*; #(
    parameter int VectorSize = 4
) ();
    wordT [VectorSize-1:0] dataA;
    wordT [VectorSize-1:0] dataB;
    logic [VectorSize-1:0] laneValid;
    logic last;

    modport source (output dataA, dataB, laneValid, last);
    modport sink (input dataA, dataB, laneValid, last);
endinterface

// File: convPkg.sv
package convPkg;

    // Matrix element and result, products and sums wrap modulo 2^32
    typedef logic signed [31:0] wordT;

    // Host bus
    typedef logic [31:0] busAddrT;
    typedef logic [63:0] busDataT;
    typedef logic [7:0] busByteEnT;

    // Byte enables of one word
    typedef logic [3:0] wordByteEnT;

    // Address generator FSM
    typedef enum logic {
        stateIdle,
        stateCalc
    } convStateT;

    localparam int WordBytes = 4;

    // Two words per bus beat
    localparam int BusWords = 2;

endpackage

// File: filelist.f
convPkg.sv
convIfs.sv
busWriteMapper.sv
convAddressGen.sv
bankedMemory.sv
vectorMac.sv
resultFifo.sv
convAccel.sv
tbConvAccel.sv

// File: resultFifo.sv
`timescale 1ns/1ps

module resultFifo import convPkg::*; #(
    parameter int FifoDepth = 32,
    parameter int FifoSkid = 16
) (
    input logic clkIn,
    input logic rstIn,
    input wordT wrData,
    input logic wrValid,
    output logic wrReady,
    output wordT dataOut,
    output logic validOut,
    input logic readyIn
);
    localparam int PtrW = $clog2(FifoDepth);
    localparam int CntW = $clog2(FifoDepth + 1);

    wordT mem [FifoDepth];
    logic [PtrW-1:0] wrPtr, rdPtr;
    logic [CntW-1:0] count;
    logic doRead;

    assign validOut = count != '0;
    assign dataOut = mem[rdPtr];
    assign doRead = validOut && readyIn;
    // Early back-pressure leaves room for beats still in flight
    assign wrReady = count < CntW'(FifoDepth - FifoSkid);

    always_ff @(posedge clkIn) begin
        if (wrValid) begin
            mem[wrPtr] <= wrData;
        end
    end

    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (wrValid) begin
                wrPtr <= (wrPtr == PtrW'(FifoDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= (rdPtr == PtrW'(FifoDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
            count <= count + CntW'(wrValid) - CntW'(doRead);
        end
    end

endmodule

// File: tbConvAccel.sv
`timescale 1ns/1ps

module tbConvAccel import convPkg::*; ();
    localparam int VectorSize = 4;
    localparam int MaxSize = 256;
    localparam int FifoDepth = 32;
    localparam int SizeW = $clog2(MaxSize) + 1;
    localparam int DrainCycles = 40;
    localparam int Jobs = 8;
    // Beats per job are windows times filter rows times column groups
    localparam int JobBeats = 36*3 + 48*10 + 196*3 + 30 + 16 + 16*3 + 36*3 + 32*4;
    localparam int LoadBeats = 500;
    localparam int TimeoutCycles = 10 * (JobBeats + LoadBeats + Jobs * DrainCycles);

    logic clkIn;
    logic rstIn;
    logic startIn;
    logic [SizeW-1:0] filtRowsIn, filtColsIn, dataRowsIn, dataColsIn;
    busAddrT addrIn;
    busByteEnT wrEnIn;
    busDataT wrDataIn;
    logic readyIn;
    logic validOut;
    wordT dataOut;

    // Reference copies of both matrices
    wordT dataMem [MaxSize];
    wordT filtMem [MaxSize];
    logic [15:0] lfsrState;
    int errCnt = 0;
    int checkCnt = 0;
    int testNum = 0;
    int testsWithErr = 0;
    int cycleCnt = 0;

    convAccel #(.VectorSize(VectorSize), .MaxSize(MaxSize), .FifoDepth(FifoDepth)) uut (
        .clkIn(clkIn),
        .rstIn(rstIn),
        .startIn(startIn),
        .filtRowsIn(filtRowsIn),
        .filtColsIn(filtColsIn),
        .dataRowsIn(dataRowsIn),
        .dataColsIn(dataColsIn),
        .addrIn(addrIn),
        .wrEnIn(wrEnIn),
        .wrDataIn(wrDataIn),
        .readyIn(readyIn),
        .validOut(validOut),
        .dataOut(dataOut)
    );

    initial begin
        clkIn = 1'b0;
        forever #2 clkIn = ~clkIn;
    end

    always @(posedge clkIn) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt >= TimeoutCycles) begin
            $display("timeout: the run did not complete within %0d cycles", TimeoutCycles);
            $display("tests failed");
            $finish;
        end
    end

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsrState[15]};
            fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], fb};
        end
        return v;
    endfunction

    // Sign-extended 8-bit value
    function automatic wordT randWord();
        logic [7:0] b;
        b = 8'(takeBits(8));
        return {{24{b[7]}}, b};
    endfunction

    task automatic checkWord(input string name, input wordT got, input wordT exp);
        checkCnt++;
        if (got !== exp) begin
            errCnt++;
            $display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        checkCnt++;
        if (got != exp) begin
            errCnt++;
            $display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // One bus beat covers elements 2p and 2p+1
    // Enabled bytes are merged into the model too
    task automatic busWrite(input logic isFilt, input int pair, input busByteEnT en,
                            input busDataT data);
        busAddrT addr;
        addr = busAddrT'(pair * BusWords * WordBytes);
        if (isFilt) begin
            addr = addr + busAddrT'(MaxSize * WordBytes);
        end
        for (int w = 0; w < BusWords; w++) begin
            for (int b = 0; b < WordBytes; b++) begin
                if (en[w*WordBytes + b]) begin
                    if (isFilt) begin
                        filtMem[2*pair + w][b*8 +: 8] = data[w*32 + b*8 +: 8];
                    end else begin
                        dataMem[2*pair + w][b*8 +: 8] = data[w*32 + b*8 +: 8];
                    end
                end
            end
        end
        addrIn = addr;
        wrEnIn = en;
        wrDataIn = data;
        @(negedge clkIn);
    endtask

    task automatic loadMatrix(input logic isFilt, input int count);
        for (int e = 0; e < count; e++) begin
            if (isFilt) begin
                filtMem[e] = randWord();
            end else begin
                dataMem[e] = randWord();
            end
        end
        for (int p = 0; p < (count + 1) / 2; p++) begin
            if (isFilt) begin
                busWrite(1'b1, p, 8'hFF, {filtMem[2*p + 1], filtMem[2*p]});
            end else begin
                busWrite(1'b0, p, 8'hFF, {dataMem[2*p + 1], dataMem[2*p]});
            end
        end
        wrEnIn = '0;
        @(negedge clkIn);
    endtask

    // Start a job, collect every result in order, then watch for extras
    task automatic runJob(input int fr, input int fc, input int dr, input int dc,
                          input logic randReady, input int restartAt);
        wordT expQ[$];
        wordT sum;
        int got;
        int extra;
        int cyc;
        int holdLeft;
        logic readyLvl;
        for (int r = 0; r <= dr - fr; r++) begin
            for (int c = 0; c <= dc - fc; c++) begin
                sum = '0;
                for (int i = 0; i < fr; i++) begin
                    for (int j = 0; j < fc; j++) begin
                        sum = sum + dataMem[(r + i) * dc + c + j] * filtMem[i * fc + j];
                    end
                end
                expQ.push_back(sum);
            end
        end
        got = 0;
        extra = 0;
        cyc = 0;
        holdLeft = 0;
        readyLvl = 1'b1;
        filtRowsIn = SizeW'(fr);
        filtColsIn = SizeW'(fc);
        dataRowsIn = SizeW'(dr);
        dataColsIn = SizeW'(dc);
        startIn = 1'b1;
        @(negedge clkIn);
        startIn = 1'b0;
        while (got < expQ.size()) begin
            @(negedge clkIn);
            cyc++;
            startIn = (cyc == restartAt);
            // Sizes that would corrupt the run if the pulse were taken
            if (cyc == restartAt) begin
                filtRowsIn = SizeW'(fr + 1);
                filtColsIn = SizeW'(fc + 1);
            end
            if (randReady) begin
                // Long stall first so the FIFO passes almost-full
                if (cyc < 120) begin
                    readyLvl = 1'b0;
                end else begin
                    if (holdLeft == 0) begin
                        readyLvl = takeBits(1) != 0;
                        holdLeft = int'(takeBits(4)) + 1;
                    end
                    holdLeft--;
                end
            end
            readyIn = randReady ? readyLvl : 1'b1;
            // Head of the queue shows while valid, ready or not
            if (validOut) begin
                checkWord("dataOut", dataOut, expQ[got]);
                if (readyIn) begin
                    got++;
                end
            end
        end
        startIn = 1'b0;
        readyIn = 1'b1;
        repeat (DrainCycles) begin
            @(negedge clkIn);
            if (validOut) begin
                extra++;
            end
        end
        checkCount("result count", got + extra, expQ.size());
    endtask

    task automatic reportTest(input string name, input int errBefore);
        testNum++;
        if (errCnt == errBefore) begin
            $display("test %0d %s: ok", testNum, name);
        end else begin
            testsWithErr++;
            $display("test %0d %s: %0d errors", testNum, name, errCnt - errBefore);
        end
    endtask

    task automatic basicWindow();
        int errBefore;
        errBefore = errCnt;
        loadMatrix(1'b0, 64);
        loadMatrix(1'b1, 9);
        runJob(3, 3, 8, 8, 1'b0, -1);
        reportTest("3x3 filter over 8x8 data", errBefore);
    endtask

    task automatic partialGroup();
        int errBefore;
        errBefore = errCnt;
        loadMatrix(1'b0, 120);
        loadMatrix(1'b1, 25);
        runJob(5, 5, 12, 10, 1'b0, -1);
        reportTest("5x5 filter over 12x10 data", errBefore);
    endtask

    task automatic backPressure();
        int errBefore;
        errBefore = errCnt;
        loadMatrix(1'b0, 256);
        loadMatrix(1'b1, 9);
        runJob(3, 3, 16, 16, 1'b1, -1);
        reportTest("random ready with back-pressure", errBefore);
    endtask

    task automatic edgeFilters();
        int errBefore;
        errBefore = errCnt;
        loadMatrix(1'b0, 30);
        loadMatrix(1'b1, 1);
        runJob(1, 1, 6, 5, 1'b0, -1);
        // Filter as large as the data gives one dot product
        loadMatrix(1'b0, 64);
        loadMatrix(1'b1, 64);
        runJob(8, 8, 8, 8, 1'b0, -1);
        reportTest("1x1 and full-size filters", errBefore);
    endtask

    task automatic byteMerge();
        int errBefore;
        int pair;
        busByteEnT en;
        logic [31:0] hi, lo;
        errBefore = errCnt;
        loadMatrix(1'b0, 36);
        loadMatrix(1'b1, 9);
        for (int k = 0; k < 6; k++) begin
            pair = int'(takeBits(4));
            en = busByteEnT'(takeBits(8));
            if (en == 8'hFF || en == 8'h00) begin
                en = 8'h5A;
            end
            hi = takeBits(32);
            lo = takeBits(32);
            busWrite(1'b0, pair, en, {hi, lo});
        end
        hi = takeBits(32);
        lo = takeBits(32);
        busWrite(1'b1, 2, 8'h91, {hi, lo});
        wrEnIn = '0;
        @(negedge clkIn);
        runJob(3, 3, 6, 6, 1'b0, -1);
        reportTest("partial byte enables", errBefore);
    endtask

    task automatic restartIgnored();
        int errBefore;
        errBefore = errCnt;
        loadMatrix(1'b0, 64);
        loadMatrix(1'b1, 9);
        runJob(3, 3, 8, 8, 1'b0, 6);
        // Fresh job with new sizes after completion
        loadMatrix(1'b0, 63);
        loadMatrix(1'b1, 8);
        runJob(4, 2, 7, 9, 1'b0, -1);
        reportTest("start during run and second job", errBefore);
    endtask

    initial begin
        rstIn = 1'b1;
        startIn = 1'b0;
        filtRowsIn = '0;
        filtColsIn = '0;
        dataRowsIn = '0;
        dataColsIn = '0;
        addrIn = '0;
        wrEnIn = '0;
        wrDataIn = '0;
        readyIn = 1'b1;
        lfsrState = 16'd35230;
        for (int i = 0; i < MaxSize; i++) begin
            dataMem[i] = '0;
            filtMem[i] = '0;
        end
        repeat (5) @(negedge clkIn);
        rstIn = 1'b0;
        @(negedge clkIn);
        basicWindow();
        partialGroup();
        backPressure();
        edgeFilters();
        byteMerge();
        restartIgnored();
        $display("summary: %0d tests, %0d with errors, %0d checks, %0d errors",
                 testNum, testsWithErr, checkCnt, errCnt);
        if (errCnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: vectorMac.sv
`timescale 1ns/1ps

module vectorMac import convPkg::*; #(
    parameter int VectorSize = 4
) (
    input logic clkIn,
    input logic rstIn,
    vectorIf.sink vec,
    output wordT macData,
    output logic macValid
);
    wordT beatSum;
    wordT acc;

    // Products and sum wrap at 32 bits
    always_comb begin
        beatSum = '0;
        for (int k = 0; k < VectorSize; k++) begin
            if (vec.laneValid[k]) begin
                beatSum = beatSum + vec.dataA[k] * vec.dataB[k];
            end
        end
    end

    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            acc <= '0;
            macValid <= 1'b0;
        end else begin
            macValid <= 1'b0;
            if (|vec.laneValid) begin
                acc <= acc + beatSum;
                // Window complete, restart the total
                if (vec.last) begin
                    acc <= '0;
                    macValid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clkIn) begin
        if (vec.last) begin
            macData <= acc + beatSum;
        end
    end

endmodule
